// ==== design/axi_bus_settings.svh ====
`ifndef AXI_BUS_SETTINGS_SVH
`define AXI_BUS_SETTINGS_SVH

// bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_STRB_W 4
`define AXI_ID_W   4

// address map, one region per slave
`define S0_START_ADDR 32'h0000_0000
`define S0_END_ADDR   32'h0FFF_FFFF
`define S1_START_ADDR 32'h1000_0000
`define S1_END_ADDR   32'h1FFF_FF0F
`define S2_START_ADDR 32'h2000_0000
`define S2_END_ADDR   32'h2FFF_FF0F
`define S3_START_ADDR 32'h3000_0000
`define S3_END_ADDR   32'h3FFF_FF0F

`define MEM_DEPTH 256   // words, addr bits 9:2

`define RESP_OKAY   2'd0
`define RESP_DECERR 2'd3

// fixed panel pages 4..7
`define PANEL_PAT0 8'hAA
`define PANEL_PAT1 8'h55
`define PANEL_PAT2 8'hF0
`define PANEL_PAT3 8'h0F

`endif

// ==== design/axi_bus_pkg.sv ====
`include "axi_bus_settings.svh"

package axi_bus_pkg;

    // single-beat request from the outside master
    typedef struct packed {
        logic                   write;
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_DATA_W-1:0] wdata;
        logic [`AXI_STRB_W-1:0] strb;
    } bus_req_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] rdata;
        logic [1:0]             resp;
    } bus_rsp_t;

    typedef enum logic [1:0] {
        SEL_MEM,
        SEL_LED,
        SEL_ERR   // jtag, default slave and unmapped space
    } slave_sel_t;

    // request as seen by the slaves, with its decoded target
    typedef struct packed {
        logic                   write;
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_DATA_W-1:0] wdata;
        logic [`AXI_STRB_W-1:0] strb;
        slave_sel_t             sel;
    } slave_req_t;

endpackage

// ==== design/bus_request_decoder.sv ====
`include "axi_bus_settings.svh"

module bus_request_decoder
    import axi_bus_pkg::*;
(
    input  logic       sys_clk,
    input  logic       rst_n,
    input  logic       req_valid,
    output logic       req_ready,
    input  bus_req_t   req,
    input  logic       rsp_done,
    output slave_req_t slave_req,
    output logic       slave_stb
);

    function automatic slave_sel_t decode_region(input logic [`AXI_ADDR_W-1:0] addr);
        if (addr >= `S0_START_ADDR && addr <= `S0_END_ADDR) begin
            return SEL_MEM;
        end
        if (addr >= `S2_START_ADDR && addr <= `S2_END_ADDR) begin
            return SEL_LED;
        end
        // region 1 has no jtag slave here, region 3 is the default slave
        return SEL_ERR;
    endfunction

    logic       busy;
    logic       accept;
    slave_sel_t req_sel;

    assign req_ready = ~busy;   // one request in flight
    assign accept    = req_valid & req_ready;
    assign req_sel   = decode_region(req.addr);

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            slave_stb <= 1'b0;
        end else begin
            slave_stb <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (rsp_done) begin
                busy <= 1'b0;   // response has left
            end
        end
    end

    // held until the next acceptance
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            slave_req.write <= req.write;
            slave_req.id    <= req.id;
            slave_req.addr  <= req.addr;
            slave_req.wdata <= req.wdata;
            slave_req.strb  <= req.strb;
            slave_req.sel   <= req_sel;
        end
    end

endmodule

// ==== design/mem_slave.sv ====
`include "axi_bus_settings.svh"

module mem_slave
    import axi_bus_pkg::*;
(
    input  logic                   sys_clk,
    input  slave_req_t             slave_req,
    input  logic                   slave_stb,
    output logic [`AXI_DATA_W-1:0] mem_rdata
);

    localparam int IDX_W = $clog2(`MEM_DEPTH);

    logic [`AXI_DATA_W-1:0] mem [0:`MEM_DEPTH-1];
    logic [IDX_W-1:0]       idx;
    logic                   hit;

    // word index, upper region bits alias
    assign idx = slave_req.addr[IDX_W+1:2];
    assign hit = slave_stb && (slave_req.sel == SEL_MEM);

    always_ff @(posedge sys_clk) begin
        if (hit && slave_req.write) begin
            for (int i = 0; i < `AXI_STRB_W; i++) begin
                if (slave_req.strb[i]) begin
                    mem[idx][i*8 +: 8] <= slave_req.wdata[i*8 +: 8];
                end
            end
        end
    end

    // registered read, stays put until the next hit
    always_ff @(posedge sys_clk) begin
        if (hit) begin
            mem_rdata <= mem[idx];
        end
    end

endmodule

// ==== design/led_slave.sv ====
`include "axi_bus_settings.svh"

module led_slave
    import axi_bus_pkg::*;
(
    input  logic                   sys_clk,
    input  logic                   rst_n,
    input  slave_req_t             slave_req,
    input  logic                   slave_stb,
    output logic [`AXI_DATA_W-1:0] led_rdata,
    output logic [`AXI_DATA_W-1:0] led_value
);

    logic [`AXI_DATA_W-1:0] led_reg;
    logic                   hit;

    // single register, offset within the region is ignored
    assign hit       = slave_stb && (slave_req.sel == SEL_LED);
    assign led_value = led_reg;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            led_reg <= '0;
        end else if (hit && slave_req.write) begin
            for (int i = 0; i < `AXI_STRB_W; i++) begin
                if (slave_req.strb[i]) begin
                    led_reg[i*8 +: 8] <= slave_req.wdata[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (hit) begin
            led_rdata <= led_reg;
        end
    end

endmodule

// ==== design/bus_response_stage.sv ====
`include "axi_bus_settings.svh"

module bus_response_stage
    import axi_bus_pkg::*;
(
    input  logic                   sys_clk,
    input  logic                   rst_n,
    input  slave_req_t             slave_req,
    input  logic                   slave_stb,
    input  logic [`AXI_DATA_W-1:0] mem_rdata,
    input  logic [`AXI_DATA_W-1:0] led_rdata,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output bus_rsp_t               rsp,
    output logic                   rsp_done
);

    logic                 stb_q;       // slave data ready this cycle
    logic [`AXI_ID_W-1:0] pend_id;
    slave_sel_t           pend_sel;
    logic                 pend_write;
    bus_rsp_t             rsp_next;

    assign rsp_done = rsp_valid & rsp_ready;

    always_comb begin
        rsp_next.id    = pend_id;
        rsp_next.resp  = `RESP_OKAY;
        rsp_next.rdata = '0;
        case (pend_sel)
            SEL_MEM: rsp_next.rdata = pend_write ? '0 : mem_rdata;
            SEL_LED: rsp_next.rdata = pend_write ? '0 : led_rdata;
            default: rsp_next.resp  = `RESP_DECERR;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            stb_q     <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            stb_q <= slave_stb;
            if (stb_q) begin
                rsp_valid <= 1'b1;
            end else if (rsp_done) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (slave_stb) begin
            pend_id    <= slave_req.id;
            pend_sel   <= slave_req.sel;
            pend_write <= slave_req.write;
        end
        if (stb_q) begin
            rsp <= rsp_next;   // held while rsp_ready is low
        end
    end

endmodule

// ==== design/led_panel.sv ====
`include "axi_bus_settings.svh"

module led_panel
    import axi_bus_pkg::*;
(
    input  logic                   sys_clk,
    input  logic                   rst_n,
    input  logic                   btn_up,
    input  logic                   btn_down,
    input  logic [`AXI_DATA_W-1:0] led_value,
    output logic [7:0]             led8,
    output logic [3:0]             led4
);

    logic [1:0] btn_s1;     // {down, up}
    logic [1:0] btn_s2;
    logic [1:0] btn_rise;
    logic [2:0] page;
    logic [7:0] pat_byte;
    logic [7:0] shown;

    assign btn_rise = btn_s1 & ~btn_s2;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            btn_s1 <= '0;
            btn_s2 <= '0;
        end else begin
            btn_s1 <= {btn_down, btn_up};
            btn_s2 <= btn_s1;
        end
    end

    // wraps both ways, simultaneous presses cancel
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            page <= '0;
        end else begin
            case (btn_rise)
                2'b01:   page <= page + 3'd1;
                2'b10:   page <= page - 3'd1;
                default: page <= page;
            endcase
        end
    end

    always_comb begin
        case (page[1:0])
            2'd0:    pat_byte = `PANEL_PAT0;
            2'd1:    pat_byte = `PANEL_PAT1;
            2'd2:    pat_byte = `PANEL_PAT2;
            default: pat_byte = `PANEL_PAT3;
        endcase
    end

    // pages 0..3 are the led register, byte 0 first
    assign shown = page[2] ? pat_byte : led_value[page[1:0]*8 +: 8];
    assign led8  = ~shown;   // active low
    assign led4  = {1'b0, page};

endmodule

// ==== design/udp_axi_ddr_top.sv ====
`include "axi_bus_settings.svh"

module udp_axi_ddr_top
    import axi_bus_pkg::*;
(
    input  logic       sys_clk,
    input  logic       rst_n,
    input  logic       req_valid,
    output logic       req_ready,
    input  bus_req_t   req,
    output logic       rsp_valid,
    input  logic       rsp_ready,
    output bus_rsp_t   rsp,
    input  logic       btn_up,
    input  logic       btn_down,
    output logic [7:0] led8,
    output logic [3:0] led4
);

    slave_req_t             slave_req;
    logic                   slave_stb;
    logic                   rsp_done;
    logic [`AXI_DATA_W-1:0] mem_rdata;
    logic [`AXI_DATA_W-1:0] led_rdata;
    logic [`AXI_DATA_W-1:0] led_value;

    bus_request_decoder u_decoder (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_done  (rsp_done),
        .slave_req (slave_req),
        .slave_stb (slave_stb)
    );

    // region 0, stands in for the ddr slave
    mem_slave u_mem (
        .sys_clk   (sys_clk),
        .slave_req (slave_req),
        .slave_stb (slave_stb),
        .mem_rdata (mem_rdata)
    );

    led_slave u_led (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .slave_req (slave_req),
        .slave_stb (slave_stb),
        .led_rdata (led_rdata),
        .led_value (led_value)
    );

    bus_response_stage u_rsp (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .slave_req (slave_req),
        .slave_stb (slave_stb),
        .mem_rdata (mem_rdata),
        .led_rdata (led_rdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .rsp_done  (rsp_done)
    );

    led_panel u_panel (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .btn_up    (btn_up),
        .btn_down  (btn_down),
        .led_value (led_value),
        .led8      (led8),
        .led4      (led4)
    );

endmodule

// ==== dv/bus_checker.sv ====
`include "axi_bus_settings.svh"

module bus_checker
    import axi_bus_pkg::*;
(
    input  logic       sys_clk,
    input  logic       rst_n,
    input  logic       req_valid,
    input  logic       req_ready,
    input  bus_req_t   req,
    input  logic       rsp_valid,
    input  logic       rsp_ready,
    input  bus_rsp_t   rsp,
    input  logic       btn_up,
    input  logic       btn_down,
    input  logic [7:0] led8,
    input  logic [3:0] led4,
    output int         value_errs,
    output int         proto_errs,
    output int         n_accepted,
    output int         n_responses
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] mem_model [0:`MEM_DEPTH-1];
    logic [31:0] led_model;
    logic [31:0] led_d1;     // led register as the panel shows it, two edges late
    logic [31:0] led_d2;
    logic [2:0]  page;
    logic [1:0]  btn_prev;
    int          settle;     // edges since the buttons last changed
    logic        in_reset;
    logic        pending;
    logic        rsp_seen;
    int          acc_cyc;
    int          cyc;
    bus_rsp_t    exp_rsp;
    bus_rsp_t    held_rsp;
    string       exp_name;

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (act !== exp) begin
            value_errs++;
            $display("Fail %s: expected 0x%0h actual 0x%0h (cycle %0d)", name, exp, act, cyc);
        end
    endtask

    task automatic protocol_error(input string what);
        proto_errs++;
        $display("ERROR: %s (cycle %0d)", what, cyc);
    endtask

    function automatic logic [7:0] pattern_byte(input logic [1:0] sel);
        case (sel)
            2'd0:    return `PANEL_PAT0;
            2'd1:    return `PANEL_PAT1;
            2'd2:    return `PANEL_PAT2;
            default: return `PANEL_PAT3;
        endcase
    endfunction

    task automatic model_request(input bus_req_t r);
        logic [7:0] idx;
        idx           = r.addr[9:2];
        exp_rsp.id    = r.id;
        exp_rsp.rdata = '0;
        exp_rsp.resp  = `RESP_OKAY;
        if (r.addr >= `S0_START_ADDR && r.addr <= `S0_END_ADDR) begin
            exp_name = r.write ? "mem_write" : "mem_read";
            if (!r.write) exp_rsp.rdata = mem_model[idx];
            for (int i = 0; i < 4; i++) begin
                if (r.write && r.strb[i]) mem_model[idx][i*8 +: 8] = r.wdata[i*8 +: 8];
            end
        end else if (r.addr >= `S2_START_ADDR && r.addr <= `S2_END_ADDR) begin
            exp_name = r.write ? "led_write" : "led_read";
            if (!r.write) exp_rsp.rdata = led_model;
            for (int i = 0; i < 4; i++) begin
                if (r.write && r.strb[i]) led_model[i*8 +: 8] = r.wdata[i*8 +: 8];
            end
        end else begin
            exp_name     = "decode_error";   // jtag, default slave, unmapped
            exp_rsp.resp = `RESP_DECERR;
        end
    endtask

    task automatic check_panel();
        logic [1:0] btn_now;
        logic [1:0] rise;
        logic [7:0] exp_led8;
        btn_now = {btn_down, btn_up};
        rise    = btn_now & ~btn_prev;
        if (rise == 2'b01) page = page + 3'd1;
        else if (rise == 2'b10) page = page - 3'd1;
        if (btn_now != btn_prev) settle = 0;
        else if (settle < 2) settle++;
        btn_prev = btn_now;
        if (settle >= 2) begin
            exp_led8 = page[2] ? ~pattern_byte(page[1:0]) : ~led_d2[page[1:0]*8 +: 8];
            check_value("panel_led4", page, led4);
            check_value("panel_led8", exp_led8, led8);
        end
    endtask

    task automatic check_handshake();
        int latency;
        if (pending && req_ready) protocol_error("req_ready high while a response is pending");
        if (!pending && !req_ready) protocol_error("req_ready low with no request in flight");
        if (rsp_valid) begin
            if (!pending) begin
                protocol_error("rsp_valid high with no request in flight");
            end else if (!rsp_seen) begin
                latency = cyc - acc_cyc - 1;
                check_value("rsp_latency", 64'd2, latency);
                check_value({exp_name, ".id"}, exp_rsp.id, rsp.id);
                check_value({exp_name, ".rdata"}, exp_rsp.rdata, rsp.rdata);
                check_value({exp_name, ".resp"}, exp_rsp.resp, rsp.resp);
                held_rsp = rsp;
                rsp_seen = 1'b1;
            end else begin
                check_value("rsp_stable", held_rsp, rsp);
            end
            if (rsp_ready && pending) begin
                pending  = 1'b0;
                rsp_seen = 1'b0;
                n_responses++;
            end
        end else if (rsp_seen) begin
            protocol_error("rsp_valid dropped before the response was taken");
            pending  = 1'b0;
            rsp_seen = 1'b0;
        end
        if (req_valid && req_ready) begin
            model_request(req);
            pending = 1'b1;
            acc_cyc = cyc;
            n_accepted++;
        end
    endtask

    always @(posedge sys_clk) begin
        if (!rst_n) begin
            led_model = '0;
            led_d1    = '0;
            led_d2    = '0;
            page      = '0;
            btn_prev  = '0;
            settle    = 2;
            pending   = 1'b0;
            rsp_seen  = 1'b0;
            in_reset  = 1'b1;
            cyc       = 0;
        end else begin
            if (in_reset) begin
                check_value("reset_req_ready", 64'd1, req_ready);
                check_value("reset_rsp_valid", 64'd0, rsp_valid);
                check_value("reset_led4", 64'd0, led4);
                check_value("reset_led8", 64'hFF, led8);
                in_reset = 1'b0;
            end
            check_panel();
            check_handshake();
            led_d2 = led_d1;
            led_d1 = led_model;
            cyc++;
        end
    end

endmodule

// ==== dv/tb_top.sv ====
`include "axi_bus_settings.svh"

module tb_top
    import axi_bus_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_RANDOM   = 400;
    localparam int WAIT_LIMIT = 64;   // cycles
    localparam int DRV        = 2;    // ns after the rising edge

    logic       sys_clk;
    logic       rst_n;
    logic       req_valid;
    logic       req_ready;
    bus_req_t   req;
    logic       rsp_valid;
    logic       rsp_ready;
    bus_rsp_t   rsp;
    logic       btn_up;
    logic       btn_down;
    logic [7:0] led8;
    logic [3:0] led4;
    int         value_errs;
    int         proto_errs;
    int         n_accepted;
    int         n_responses;
    int         timeout_errs;
    int         count_errs;
    int         n_sent;
    logic       bus_done;
    logic       buttons_done;

    udp_axi_ddr_top dut (.*);

    bus_checker chk (.*);

    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;
    end

    task automatic next_cycle();
        @(posedge sys_clk);
        #DRV;
    endtask

    task automatic note_timeout(input string what);
        timeout_errs++;
        $display("ERROR: timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
    endtask

    function automatic logic [31:0] fill_word(input int w);
        logic [7:0] b;
        b = w[7:0];
        return {b ^ 8'hA5, ~b, b, b + 8'h3C};
    endfunction

    function automatic bus_req_t random_request();
        bus_req_t    r;
        int          pick;
        logic [31:0] upper;
        logic [31:0] word;
        logic [31:0] low;
        pick    = $urandom_range(99);
        r.write = 1'($urandom_range(1));
        r.id    = 4'($urandom_range(15));
        r.wdata = $urandom;
        r.strb  = 4'($urandom_range(15));
        upper   = $urandom;
        word    = $urandom_range(15);
        low     = $urandom;
        if (pick < 60) begin
            // random upper bits alias onto the first 16 words
            r.addr = (upper & 32'h0FFF_FC00) | (word << 2) | (low & 32'h3);
        end else if (pick < 80) begin
            r.addr = `S2_START_ADDR | (upper & 32'h0000_0FFC);
        end else if (pick < 87) begin
            // would land on a word that random reads look at
            r.addr = `S1_START_ADDR | (upper & 32'h0FFF_FC3F);
        end else if (pick < 94) begin
            r.addr = `S3_START_ADDR | (upper & 32'h0FFF_FC3F);
        end else begin
            r.addr = 32'h4000_0000 + (upper % 32'hC000_0000);   // unmapped
        end
        return r;
    endfunction

    task automatic await_response();
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < WAIT_LIMIT) begin
            rsp_ready = ($urandom_range(99) < 65);   // back-pressure
            taken     = rsp_valid & rsp_ready;
            next_cycle();
            waited++;
        end
        if (!taken) note_timeout("a response");
    endtask

    task automatic do_transfer(input bus_req_t r);
        int waited;
        waited    = 0;
        req       = r;
        req_valid = 1'b1;
        while (!req_ready && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!req_ready) begin
            note_timeout("req_ready");
            req_valid = 1'b0;
        end else begin
            next_cycle();   // taken on this edge
            req_valid = 1'b0;
            n_sent++;
            await_response();
        end
    endtask

    task automatic press(input logic up, input logic down);
        btn_up   = up;
        btn_down = down;
        repeat (3) next_cycle();
        btn_up   = 1'b0;
        btn_down = 1'b0;
        repeat (3) next_cycle();
    endtask

    task automatic run_buttons();
        int pick;
        int idle;
        // wraps 0->7 going down and 7->0 going up
        press(1'b0, 1'b1);
        press(1'b0, 1'b1);
        press(1'b1, 1'b0);
        press(1'b1, 1'b0);
        press(1'b1, 1'b0);
        while (!bus_done) begin
            idle = $urandom_range(12, 2);
            repeat (idle) next_cycle();
            pick = $urandom_range(99);
            if (pick < 45) press(1'b1, 1'b0);
            else if (pick < 90) press(1'b0, 1'b1);
            else press(1'b1, 1'b1);
        end
        buttons_done = 1'b1;
    endtask

    initial begin
        bus_req_t r;
        int       waited;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        rsp_ready    = 1'b0;
        btn_up       = 1'b0;
        btn_down     = 1'b0;
        timeout_errs = 0;
        count_errs   = 0;
        n_sent       = 0;
        bus_done     = 1'b0;
        buttons_done = 1'b0;
        void'($urandom(32'h122d));
        repeat (3) @(posedge sys_clk);
        #DRV;
        rst_n  = 1'b1;
        waited = 0;
        while (!req_ready && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!req_ready) note_timeout("req_ready after reset");
        fork
            run_buttons();
        join_none
        // every memory word gets a known value first
        for (int w = 0; w < `MEM_DEPTH; w++) begin
            r.write = 1'b1;
            r.id    = 4'(w);
            r.addr  = `S0_START_ADDR | (32'(w) << 2);
            r.wdata = fill_word(w);
            r.strb  = 4'hF;
            do_transfer(r);
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            do_transfer(random_request());
            repeat ($urandom_range(2)) next_cycle();
        end
        bus_done = 1'b1;
        waited   = 0;
        while (!buttons_done && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!buttons_done) note_timeout("the last button press");
        repeat (4) next_cycle();
        if (n_accepted != n_sent || n_responses != n_sent) begin
            count_errs++;
            $display("ERROR: sent %0d requests, checker saw %0d accepted and %0d responses",
                     n_sent, n_accepted, n_responses);
        end
        $display("errors: value %0d, protocol %0d, timeout %0d, count %0d",
                 value_errs, proto_errs, timeout_errs, count_errs);
        if (value_errs + proto_errs + timeout_errs + count_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+design
design/axi_bus_pkg.sv
design/bus_request_decoder.sv
design/mem_slave.sv
design/led_slave.sv
design/bus_response_stage.sv
design/led_panel.sv
design/udp_axi_ddr_top.sv
dv/bus_checker.sv
dv/tb_top.sv
